/* list.f */
+incdir+.
udp_rx_pkg.sv
rx_sync_fifo.sv
rx_header_parser.sv
rx_app_buffer.sv
rx_cpu_buffer.sv
udp_rx_top.sv
udp_rx_sva.sv
udp_rx_tb.sv

/* Makefile */
TOP = udp_rx_tb

all: run

build:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -o sim

run: build
	@out=$$(./obj_dir/sim); echo "$$out"; echo "$$out" | grep -q "^PASS: all tests$$"

lint:
	verilator --lint-only --timing --assert -f list.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean

/* udp_rx_tb.sv */
`default_nettype none
`include "udp_rx_defs.svh"

module udp_rx_tb
  import udp_rx_pkg::*;
;

  localparam mac_addr_t LOCAL_MAC  = 48'h02_00_00_00_00_01;
  localparam ip_addr_t  LOCAL_IP   = 32'hc0a8_0001;
  localparam udp_port_t LOCAL_PORT = 16'd5000;
  localparam mac_addr_t BCAST      = 48'hffff_ffff_ffff;

  logic        mac_clk = 1'b0;
  logic        mac_rst = 1'b1;
  mac_rx_t     mac_rx = '0;
  logic        phy_rx_up = 1'b1;
  local_cfg_t  cfg = '{1'b1, LOCAL_MAC, LOCAL_IP, LOCAL_PORT};
  logic        app_rx_ack = 1'b0;
  logic        app_rx_overrun_ack = 1'b0;
  logic        app_rx_valid;
  app_word_t   app_rx_word;
  app_ctrl_t   app_rx_src;
  logic        app_rx_overrun;
  logic        psel = 1'b0;
  logic        penable = 1'b0;
  logic        pwrite = 1'b0;
  logic [11:0] paddr = '0;
  logic [31:0] pwdata = '0;
  logic [63:0] prdata;
  logic        pready;
  logic        pslverr;

  integer     seed = 32'h7aa4;
  int         errors = 0;
  int         tests = 0;
  int         failed_tests = 0;
  int         err_start;
  string      test_name;
  logic       hold_ack = 1'b0;
  logic [7:0] frm [0:511];
  int         frm_words;
  app_word_t  exp_app [0:63];
  int         exp_app_n;
  app_ctrl_t  exp_src;
  data_word_t exp_cpu [0:63];
  int         exp_cpu_n;
  app_word_t  sb_word [$];
  app_ctrl_t  sb_src [$];

  udp_rx_top uut (.*);

  always #5 mac_clk = ~mac_clk;

  task automatic fail_timeout(input string what);
    $display("Timeout while waiting for %s", what);
    $display("FAIL: see errors above");
    $finish;
  endtask

  task automatic check_app_word(input string name, input app_word_t got, input app_word_t exp);
    if (got !== exp) begin
      $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_src(input string name, input app_ctrl_t got, input app_ctrl_t exp);
    if (got !== exp) begin
      $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_cpu_word(input string name, input data_word_t got, input data_word_t exp);
    if (got !== exp) begin
      $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  // Wire order, first byte in bits 63:56, zero past the end
  function automatic data_word_t be_word(input int start);
    data_word_t w;
    for (int b = 0; b < 8; b++) begin
      w[63-8*b -: 8] = (start + b < 8 * frm_words) ? frm[start+b] : 8'h00;
    end
    return w;
  endfunction

  // 0 dropped, 1 application, 2 CPU buffer
  function automatic int expect_frame(input logic good);
    mac_addr_t dst;
    logic      is_udp;
    int        m;
    m = frm_words;
    dst = {frm[0], frm[1], frm[2], frm[3], frm[4], frm[5]};
    is_udp = {frm[12], frm[13]} == 16'h0800 && frm[14] == 8'h45 && frm[23] == 8'h11 &&
             {frm[30], frm[31], frm[32], frm[33]} == cfg.ip &&
             {frm[36], frm[37]} == cfg.port;
    exp_app_n = 0;
    exp_cpu_n = 0;
    if (dst == cfg.mac && cfg.enable && is_udp && m >= 6) begin
      exp_src.src_ip   = {frm[26], frm[27], frm[28], frm[29]};
      exp_src.src_port = {frm[34], frm[35]};
      for (int j = 0; j < m - 5; j++) begin
        exp_app[j].data    = be_word(42 + 8 * j);
        exp_app[j].eof     = j == m - 6;
        exp_app[j].bad     = j == m - 6 && !good;
        exp_app[j].overrun = 1'b0;
      end
      exp_app_n = m - 5;
      return 1;
    end
    if (dst == cfg.mac || dst == BCAST) begin
      if (good) begin
        for (int i = 0; i < m; i++) begin
          exp_cpu[i] = be_word(8 * i);
        end
        exp_cpu_n = m;
      end
      return 2;
    end
    return 0;
  endfunction

  // Guards the intent of each test against the reference classification
  task automatic confirm_class(input logic good, input int want);
    int got;
    got = expect_frame(good);
    if (got != want) begin
      $display("Reference classified the frame as %0d, the test needs %0d", got, want);
      errors++;
    end
  endtask

  task automatic build_frame(input mac_addr_t dst, input logic [15:0] etype,
                             input logic [7:0] proto, input ip_addr_t sip,
                             input udp_port_t sport, input udp_port_t dport, input int m);
    int r;
    frm_words = m;
    for (int i = 0; i < 8 * m; i++) begin
      r = $random(seed);
      frm[i] = r[7:0];
    end
    for (int b = 0; b < 6; b++) begin
      frm[b]   = dst[47-8*b -: 8];
      frm[6+b] = 8'h10 + 8'(b);
    end
    for (int b = 0; b < 4; b++) begin
      frm[26+b] = sip[31-8*b -: 8];
      frm[30+b] = LOCAL_IP[31-8*b -: 8];
    end
    {frm[12], frm[13]} = etype;
    frm[14] = 8'h45;
    frm[23] = proto;
    {frm[34], frm[35]} = sport;
    {frm[36], frm[37]} = dport;
  endtask

  task automatic push_expected();
    for (int j = 0; j < exp_app_n; j++) begin
      sb_word.push_back(exp_app[j]);
      sb_src.push_back(exp_src);
    end
  endtask

  task automatic send_frame(input logic good);
    for (int w = 0; w < frm_words; w++) begin
      @(negedge mac_clk);
      for (int b = 0; b < 8; b++) begin
        mac_rx.data[8*b +: 8] = frm[8*w+b];
      end
      mac_rx.byte_valid = 8'hff;
    end
    @(negedge mac_clk);
    mac_rx = '0;
    mac_rx.good_frame = good;
    mac_rx.bad_frame  = !good;
    @(negedge mac_clk);
    mac_rx = '0;
    repeat (2) @(negedge mac_clk);
  endtask

  task automatic apb_access(input logic wr, input logic [11:0] addr,
                            output logic [63:0] data, output logic err);
    int n;
    @(negedge mac_clk);
    psel = 1'b1;
    penable = 1'b0;
    pwrite = wr;
    paddr = addr;
    pwdata = '0;
    @(negedge mac_clk);
    penable = 1'b1;
    @(posedge mac_clk);
    n = 0;
    while (!pready) begin
      if (n == 16) fail_timeout("APB pready");
      n++;
      @(posedge mac_clk);
    end
    data = prdata;
    err = pslverr;
    @(negedge mac_clk);
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
  endtask

  task automatic wait_drained();
    int n;
    n = 0;
    while (sb_word.size() != 0) begin
      if (n == 3000) fail_timeout("application words");
      n++;
      @(negedge mac_clk);
    end
  endtask

  task automatic check_cpu_empty();
    logic [63:0] d;
    logic        e;
    repeat (6) @(negedge mac_clk);
    apb_access(1'b0, `APB_SIZE_ADDR, d, e);
    check_cpu_word("size", d, '0);
  endtask

  // Polls the size register, then reads and releases the bank
  task automatic check_cpu_frame();
    logic [63:0] d;
    logic        e;
    int          n;
    n = 0;
    d = '0;
    while (d == '0) begin
      if (n == 20) fail_timeout("CPU size register");
      n++;
      apb_access(1'b0, `APB_SIZE_ADDR, d, e);
    end
    check_cpu_word("size", d, data_word_t'(exp_cpu_n));
    for (int i = 0; i < exp_cpu_n; i++) begin
      apb_access(1'b0, 12'(8 * i), d, e);
      check_cpu_word($sformatf("cpu word %0d", i), d, exp_cpu[i]);
    end
    apb_access(1'b1, `APB_SIZE_ADDR, d, e);
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    err_start = errors;
    tests++;
  endtask

  task automatic end_test();
    if (errors != err_start) begin
      failed_tests++;
      $display("test %s: failed", test_name);
    end else begin
      $display("test %s: ok", test_name);
    end
  endtask

  // Random ack; the head is compared in the cycle it gets taken
  always @(negedge mac_clk) begin
    int   r;
    logic ack;
    r = $random(seed);
    ack = !mac_rst && !hold_ack && (r[0] || r[1]);
    if (ack && app_rx_valid) begin
      if (sb_word.size() == 0) begin
        $display("Application word arrived with nothing expected at t=%0t", $time);
        errors++;
      end else begin
        check_app_word("app_rx_word", app_rx_word, sb_word.pop_front());
        check_src("app_rx_src", app_rx_src, sb_src.pop_front());
      end
    end
    app_rx_ack = ack;
  end

  initial begin
    logic [63:0] d;
    logic        e;
    int          cnt;
    logic        cut;
    repeat (16) @(posedge mac_clk);
    @(negedge mac_clk);
    mac_rst = 1'b0;

    begin_test("reset");
    if (app_rx_valid !== 1'b0 || app_rx_overrun !== 1'b0) begin
      $display("Application outputs not idle after reset");
      errors++;
    end
    if (pready !== 1'b0 || pslverr !== 1'b0) begin
      $display("APB pready or pslverr not low after reset");
      errors++;
    end
    check_cpu_empty();
    end_test();

    begin_test("udp delivery");
    for (int k = 0; k < 3; k++) begin
      build_frame(LOCAL_MAC, 16'h0800, 8'h11, 32'h0a00_0010 + k, 16'd7000 + 16'(k),
                  LOCAL_PORT, 7 + 3 * k);
      confirm_class(1'b1, 1);
      push_expected();
      send_frame(1'b1);
    end
    wait_drained();
    check_cpu_empty();
    end_test();

    begin_test("cpu frames");
    build_frame(BCAST, 16'h0806, 8'h00, 32'h0a00_0020, 16'd1, 16'd2, 8);
    confirm_class(1'b1, 2);
    send_frame(1'b1);
    check_cpu_frame();
    build_frame(LOCAL_MAC, 16'h0800, 8'h11, 32'h0a00_0021, 16'd3, LOCAL_PORT + 16'd1, 9);
    confirm_class(1'b1, 2);
    send_frame(1'b1);
    check_cpu_frame();
    end_test();

    begin_test("drop and bad");
    build_frame(48'h02_00_00_00_00_99, 16'h0800, 8'h11, 32'h0a00_0030, 16'd4, LOCAL_PORT, 8);
    confirm_class(1'b1, 0);
    send_frame(1'b1);
    build_frame(LOCAL_MAC, 16'h0800, 8'h11, 32'h0a00_0031, 16'd5, LOCAL_PORT, 10);
    confirm_class(1'b0, 1);
    push_expected();
    send_frame(1'b0);
    wait_drained();
    check_cpu_empty();
    end_test();

    begin_test("disabled");
    cfg.enable = 1'b0;
    repeat (3) @(negedge mac_clk);
    build_frame(LOCAL_MAC, 16'h0800, 8'h11, 32'h0a00_0040, 16'd6, LOCAL_PORT, 9);
    confirm_class(1'b1, 2);
    send_frame(1'b1);
    check_cpu_frame();
    cfg.enable = 1'b1;
    repeat (3) @(negedge mac_clk);
    end_test();

    begin_test("overrun");
    hold_ack = 1'b1;
    cnt = 0;
    cut = 1'b0;
    for (int k = 0; k < 3; k++) begin
      build_frame(LOCAL_MAC, 16'h0800, 8'h11, 32'h0a00_0050 + k, 16'd8, LOCAL_PORT, 30);
      confirm_class(1'b1, 1);
      for (int j = 0; j < exp_app_n; j++) begin
        if (!cut) begin
          if (cnt >= `APP_FIFO_DEPTH - `FIFO_AF_MARGIN) begin
            exp_app[j].eof = 1'b1;
            exp_app[j].overrun = 1'b1;
            cut = 1'b1;
          end
          cnt++;
          sb_word.push_back(exp_app[j]);
          sb_src.push_back(exp_src);
        end
      end
      send_frame(1'b1);
    end
    if (app_rx_overrun !== 1'b1) begin
      $display("app_rx_overrun not raised after the FIFO filled");
      errors++;
    end
    hold_ack = 1'b0;
    wait_drained();
    if (app_rx_overrun !== 1'b1) begin
      $display("app_rx_overrun dropped before its acknowledge");
      errors++;
    end
    @(negedge mac_clk);
    app_rx_overrun_ack = 1'b1;
    @(negedge mac_clk);
    app_rx_overrun_ack = 1'b0;
    cnt = 0;
    while (app_rx_overrun) begin
      if (cnt == 20) fail_timeout("app_rx_overrun to clear");
      cnt++;
      @(negedge mac_clk);
    end
    build_frame(LOCAL_MAC, 16'h0800, 8'h11, 32'h0a00_0060, 16'd9, LOCAL_PORT, 12);
    confirm_class(1'b1, 1);
    push_expected();
    send_frame(1'b1);
    wait_drained();
    end_test();

    begin_test("apb error");
    apb_access(1'b0, 12'h804, d, e);
    if (e !== 1'b1) begin
      $display("No pslverr for unmapped address 12'h804");
      errors++;
    end
    apb_access(1'b0, 12'h7fc, d, e);
    if (e !== 1'b1) begin
      $display("No pslverr for unaligned address 12'h7fc");
      errors++;
    end
    apb_access(1'b0, 12'h010, d, e);
    if (e !== 1'b0) begin
      $display("Unexpected pslverr inside the buffer window");
      errors++;
    end
    end_test();

    $display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* udp_rx_sva.sv */
`default_nettype none

module udp_rx_sva_chk
  import udp_rx_pkg::*;
(
  input logic      mac_clk,
  input logic      mac_rst,
  input logic      psel,
  input logic      penable,
  input logic      pready,
  input logic      pslverr,
  input logic      app_rx_valid,
  input logic      app_rx_ack,
  input app_word_t app_rx_word,
  input app_ctrl_t app_rx_src,
  input logic      app_rx_overrun,
  input logic      app_rx_overrun_ack
);

  // APB responses only in the access phase
  apb_phase_a: assert property (@(posedge mac_clk)
    (pready || pslverr) |-> (psel && penable))
    else $error("APB response outside the access phase");

  reset_valid_a: assert property (@(posedge mac_clk)
    mac_rst |=> !app_rx_valid)
    else $error("app_rx_valid high during reset");

  // Head must hold until it is taken
  app_stable_a: assert property (@(posedge mac_clk) disable iff (mac_rst)
    (app_rx_valid && !app_rx_ack) |=>
      (app_rx_valid && $stable(app_rx_word) && $stable(app_rx_src)))
    else $error("application head changed without an ack");

  overrun_hold_a: assert property (@(posedge mac_clk) disable iff (mac_rst)
    $fell(app_rx_overrun) |-> $past(app_rx_overrun_ack))
    else $error("app_rx_overrun cleared without an acknowledge");

endmodule

bind udp_rx_top udp_rx_sva_chk u_sva (
  .mac_clk            (mac_clk),
  .mac_rst            (mac_rst),
  .psel               (psel),
  .penable            (penable),
  .pready             (pready),
  .pslverr            (pslverr),
  .app_rx_valid       (app_rx_valid),
  .app_rx_ack         (app_rx_ack),
  .app_rx_word        (app_rx_word),
  .app_rx_src         (app_rx_src),
  .app_rx_overrun     (app_rx_overrun),
  .app_rx_overrun_ack (app_rx_overrun_ack)
);

`default_nettype wire

/* udp_rx_top.sv */
`default_nettype none

module udp_rx_top
  import udp_rx_pkg::*;
(
  input  logic        mac_clk,
  input  logic        mac_rst,
  input  mac_rx_t     mac_rx,
  input  logic        phy_rx_up,
  input  local_cfg_t  cfg,
  input  logic        app_rx_ack,
  input  logic        app_rx_overrun_ack,
  output logic        app_rx_valid,
  output app_word_t   app_rx_word,
  output app_ctrl_t   app_rx_src,
  output logic        app_rx_overrun,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [11:0] paddr,
  input  logic [31:0] pwdata,
  output logic [63:0] prdata,
  output logic        pready,
  output logic        pslverr
);

  logic       app_valid;
  data_word_t app_data;
  logic       app_eof;
  logic       app_bad;
  app_ctrl_t  app_ctrl;
  logic       cpu_we;
  data_word_t cpu_data;
  logic       cpu_commit;
  logic       cpu_rollback;

  rx_header_parser u_parser (
    .mac_clk      (mac_clk),
    .mac_rst      (mac_rst),
    .mac_rx       (mac_rx),
    .phy_rx_up    (phy_rx_up),
    .cfg          (cfg),
    .app_valid    (app_valid),
    .app_data     (app_data),
    .app_eof      (app_eof),
    .app_bad      (app_bad),
    .app_ctrl     (app_ctrl),
    .cpu_we       (cpu_we),
    .cpu_data     (cpu_data),
    .cpu_commit   (cpu_commit),
    .cpu_rollback (cpu_rollback)
  );

  rx_app_buffer u_app_buffer (
    .mac_clk            (mac_clk),
    .mac_rst            (mac_rst),
    .app_valid          (app_valid),
    .app_data           (app_data),
    .app_eof            (app_eof),
    .app_bad            (app_bad),
    .app_ctrl           (app_ctrl),
    .app_rx_ack         (app_rx_ack),
    .app_rx_overrun_ack (app_rx_overrun_ack),
    .app_rx_valid       (app_rx_valid),
    .app_rx_word        (app_rx_word),
    .app_rx_src         (app_rx_src),
    .app_rx_overrun     (app_rx_overrun)
  );

  rx_cpu_buffer u_cpu_buffer (
    .mac_clk      (mac_clk),
    .mac_rst      (mac_rst),
    .cpu_we       (cpu_we),
    .cpu_data     (cpu_data),
    .cpu_commit   (cpu_commit),
    .cpu_rollback (cpu_rollback),
    .psel         (psel),
    .penable      (penable),
    .pwrite       (pwrite),
    .paddr        (paddr),
    .pwdata       (pwdata),
    .prdata       (prdata),
    .pready       (pready),
    .pslverr      (pslverr)
  );

endmodule

`default_nettype wire

/* rx_cpu_buffer.sv */
`default_nettype none
`include "udp_rx_defs.svh"

module rx_cpu_buffer
  import udp_rx_pkg::*;
(
  input  logic        mac_clk,
  input  logic        mac_rst,
  input  logic        cpu_we,
  input  data_word_t  cpu_data,
  input  logic        cpu_commit,
  input  logic        cpu_rollback,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [11:0] paddr,
  input  logic [31:0] pwdata,
  output logic [63:0] prdata,
  output logic        pready,
  output logic        pslverr
);

  // Two banks, the CPU reads rd_bank while the MAC fills the other
  data_word_t mem [2*`CPU_BANK_WORDS];
  cpu_state_t state;
  logic       rd_bank;
  buf_addr_t  wr_addr;
  buf_addr_t  size_q;
  buf_addr_t  rd_index;
  logic       bypass;
  logic       apb_setup;
  logic       apb_access;
  logic       size_hit;
  logic       win_hit;
  logic       size_release;
  logic       bank_free;

  assign apb_setup    = psel && !penable;
  assign apb_access   = psel && penable;
  assign size_hit     = paddr == `APB_SIZE_ADDR;
  assign win_hit      = paddr < `APB_SIZE_ADDR && paddr[2:0] == 3'b000;
  assign rd_index     = paddr[10:3];
  assign size_release = apb_access && pwrite && size_hit;
  // Release in this cycle already frees the bank
  assign bank_free    = size_q == '0 || size_release;

  always_ff @(posedge mac_clk) begin
    if (cpu_we && state == CPU_BUFFERING) begin
      mem[{~rd_bank, wr_addr}] <= cpu_data;
    end
  end

  always_ff @(posedge mac_clk) begin
    if (mac_rst) begin
      state   <= CPU_BUFFERING;
      rd_bank <= 1'b0;
      wr_addr <= '0;
      size_q  <= '0;
      bypass  <= 1'b0;
    end else begin
      if (size_release) begin
        size_q <= '0;
      end
      case (state)
        CPU_BUFFERING: begin
          if (cpu_we) begin
            // Frame too long for a bank
            if (wr_addr == '1) begin
              bypass <= 1'b1;
            end else begin
              wr_addr <= wr_addr + 1'b1;
            end
          end
          if (cpu_rollback || (cpu_commit && bypass)) begin
            wr_addr <= '0;
          end else if (cpu_commit) begin
            if (bank_free) begin
              rd_bank <= ~rd_bank;
              size_q  <= wr_addr;
              wr_addr <= '0;
            end else begin
              state <= CPU_WAITING;
            end
          end
        end
        CPU_WAITING: begin
          // A frame arriving now is lost
          if (cpu_we) begin
            bypass <= 1'b1;
          end
          if (bank_free) begin
            rd_bank <= ~rd_bank;
            size_q  <= wr_addr;
            wr_addr <= '0;
            state   <= CPU_BUFFERING;
          end
        end
        default: begin
          state <= CPU_BUFFERING;
        end
      endcase
      if (cpu_commit || cpu_rollback) begin
        bypass <= 1'b0;
      end
    end
  end

  // Read data captured in the setup phase, ready for the access phase
  always_ff @(posedge mac_clk) begin
    if (apb_setup) begin
      if (size_hit) begin
        prdata <= {56'd0, size_q};
      end else begin
        prdata <= mem[{rd_bank, rd_index}];
      end
    end
  end

  assign pready  = apb_access;
  assign pslverr = apb_access && !(size_hit || win_hit);

endmodule

`default_nettype wire

/* rx_app_buffer.sv */
`default_nettype none
`include "udp_rx_defs.svh"

module rx_app_buffer
  import udp_rx_pkg::*;
(
  input  logic       mac_clk,
  input  logic       mac_rst,
  input  logic       app_valid,
  input  data_word_t app_data,
  input  logic       app_eof,
  input  logic       app_bad,
  input  app_ctrl_t  app_ctrl,
  input  logic       app_rx_ack,
  input  logic       app_rx_overrun_ack,
  output logic       app_rx_valid,
  output app_word_t  app_rx_word,
  output app_ctrl_t  app_rx_src,
  output logic       app_rx_overrun
);

  localparam int DATA_W = $bits(app_word_t);
  localparam int CTRL_W = $bits(app_ctrl_t);

  ovr_state_t        ovr_state;
  app_word_t         wr_word;
  logic [DATA_W-1:0] data_rd;
  logic [CTRL_W-1:0] ctrl_rd;
  logic              data_af;
  logic              ctrl_af;
  logic              data_empty;
  logic              ctrl_empty;
  logic              fifo_af;
  logic              accept;
  logic              ctrl_wr;
  logic              ctrl_rd_en;
  logic              frame_open;

  assign fifo_af = data_af || ctrl_af;
  assign accept  = app_valid && ovr_state == OVR_RUN;
  // Control entry goes in with the first word of the frame
  assign ctrl_wr = accept && !frame_open;

  // Close the frame early when either FIFO is nearly full
  always_comb begin
    wr_word.data    = app_data;
    wr_word.eof     = app_eof || fifo_af;
    wr_word.bad     = app_bad;
    wr_word.overrun = fifo_af;
  end

  always_ff @(posedge mac_clk) begin
    if (mac_rst) begin
      ovr_state  <= OVR_RUN;
      frame_open <= 1'b0;
    end else begin
      // Tracks the incoming frame, written or not
      if (app_valid) begin
        frame_open <= !app_eof;
      end
      case (ovr_state)
        OVR_RUN: begin
          if (app_valid && fifo_af) begin
            ovr_state <= OVR_OVER;
          end
        end
        OVR_OVER: begin
          if (app_rx_overrun_ack) begin
            ovr_state <= OVR_WAIT_RELEASE;
          end
        end
        OVR_WAIT_RELEASE: begin
          // Resume only on a frame boundary
          if (app_valid ? app_eof : !frame_open) begin
            ovr_state <= OVR_RUN;
          end
        end
        default: begin
          ovr_state <= OVR_RUN;
        end
      endcase
    end
  end

  rx_sync_fifo #(
    .WIDTH (DATA_W),
    .DEPTH (`APP_FIFO_DEPTH)
  ) u_data_fifo (
    .mac_clk     (mac_clk),
    .mac_rst     (mac_rst),
    .wr_en       (accept),
    .wr_data     (wr_word),
    .rd_en       (app_rx_ack),
    .rd_data     (data_rd),
    .empty       (data_empty),
    .almost_full (data_af)
  );

  rx_sync_fifo #(
    .WIDTH (CTRL_W),
    .DEPTH (`CTRL_FIFO_DEPTH)
  ) u_ctrl_fifo (
    .mac_clk     (mac_clk),
    .mac_rst     (mac_rst),
    .wr_en       (ctrl_wr),
    .wr_data     (app_ctrl),
    .rd_en       (ctrl_rd_en),
    .rd_data     (ctrl_rd),
    .empty       (ctrl_empty),
    .almost_full (ctrl_af)
  );

  assign app_rx_word    = data_rd;
  assign app_rx_src     = ctrl_rd;
  assign app_rx_valid   = !data_empty && !ctrl_empty;
  assign ctrl_rd_en     = app_rx_ack && app_rx_valid && app_rx_word.eof;
  assign app_rx_overrun = ovr_state == OVR_OVER;

endmodule

`default_nettype wire

/* rx_header_parser.sv */
`default_nettype none

module rx_header_parser
  import udp_rx_pkg::*;
(
  input  logic       mac_clk,
  input  logic       mac_rst,
  input  mac_rx_t    mac_rx,
  input  logic       phy_rx_up,
  input  local_cfg_t cfg,
  output logic       app_valid,
  output data_word_t app_data,
  output logic       app_eof,
  output logic       app_bad,
  output app_ctrl_t  app_ctrl,
  output logic       cpu_we,
  output data_word_t cpu_data,
  output logic       cpu_commit,
  output logic       cpu_rollback
);

  // Put frame byte 0 in bits 63:56 so fields read in wire order
  function automatic data_word_t swap_bytes(input data_word_t w);
    data_word_t r;
    for (int i = 0; i < 8; i++) begin
      r[8*i +: 8] = w[56-8*i +: 8];
    end
    return r;
  endfunction

  parse_state_t state;
  data_word_t   cur_r;
  data_word_t   prev_r;
  app_ctrl_t    src_q;
  mac_addr_t    dst_mac;
  ip_addr_t     dst_ip;
  udp_port_t    dst_port;
  logic         word_in;
  logic         frame_end;
  logic         mac_local;
  logic         mac_hit;
  logic         app_ok;
  logic         cpu_ok;
  logic         en_q;
  logic         wr_q;
  logic         to_app;
  logic         to_cpu;

  assign word_in   = &mac_rx.byte_valid;
  assign frame_end = mac_rx.good_frame || mac_rx.bad_frame;
  assign cur_r     = swap_bytes(mac_rx.data);

  assign dst_mac   = cur_r[63:16];
  // Destination IP straddles header words 3 and 4
  assign dst_ip    = {prev_r[15:0], cur_r[63:48]};
  assign dst_port  = cur_r[31:16];
  assign mac_local = dst_mac == cfg.mac;
  assign mac_hit   = mac_local || dst_mac == '1;

  // An app frame must have reached its payload to count as one
  assign to_app = app_ok && state == PS_DATA;
  assign to_cpu = cpu_ok && !to_app;

  always_ff @(posedge mac_clk) begin
    if (mac_rst) begin
      state        <= PS_IDLE;
      app_ok       <= 1'b0;
      cpu_ok       <= 1'b0;
      en_q         <= 1'b0;
      wr_q         <= 1'b0;
      cpu_commit   <= 1'b0;
      cpu_rollback <= 1'b0;
    end else begin
      en_q         <= cfg.enable;
      wr_q         <= word_in && state != PS_DROP && (state != PS_IDLE || phy_rx_up);
      cpu_commit   <= frame_end && state != PS_IDLE && mac_rx.good_frame && to_cpu;
      cpu_rollback <= frame_end && state != PS_IDLE && !(mac_rx.good_frame && to_cpu);
      if (frame_end) begin
        state <= PS_IDLE;
      end else if (word_in) begin
        case (state)
          PS_IDLE: begin
            if (phy_rx_up) begin
              cpu_ok <= mac_hit;
              app_ok <= mac_local && en_q;
              state  <= mac_hit ? PS_HDR1 : PS_DROP;
            end
          end
          PS_HDR1: begin
            // Ethertype 0800 and IPv4 without options
            if (cur_r[31:16] != 16'h0800 || cur_r[15:8] != 8'h45) begin
              app_ok <= 1'b0;
            end
            state <= PS_HDR2;
          end
          PS_HDR2: begin
            if (cur_r[7:0] != 8'h11) begin
              app_ok <= 1'b0;
            end
            state <= PS_HDR3;
          end
          PS_HDR3: begin
            state <= PS_HDR4;
          end
          PS_HDR4: begin
            if (dst_ip != cfg.ip || dst_port != cfg.port) begin
              app_ok <= 1'b0;
            end
            state <= PS_HDR5;
          end
          PS_HDR5: begin
            state <= PS_DATA;
          end
          default: begin
            // Data and drop hold until the end pulse
            state <= state;
          end
        endcase
      end
    end
  end

  always_ff @(posedge mac_clk) begin
    if (word_in) begin
      prev_r <= cur_r;
      if (state == PS_HDR3) begin
        src_q.src_ip <= cur_r[47:16];
      end
      if (state == PS_HDR4) begin
        src_q.src_port <= cur_r[47:32];
      end
    end
  end

  // Payload starts at byte 42, i.e. byte 2 of word 5
  assign app_valid = to_app && (word_in || frame_end);
  assign app_data  = {prev_r[47:0], word_in ? cur_r[63:48] : 16'h0000};
  assign app_eof   = frame_end;
  assign app_bad   = mac_rx.bad_frame;
  assign app_ctrl  = src_q;

  // CPU gets every word of the frame, one cycle late
  assign cpu_we   = wr_q && cpu_ok;
  assign cpu_data = prev_r;

endmodule

`default_nettype wire

/* rx_sync_fifo.sv */
`default_nettype none
`include "udp_rx_defs.svh"

module rx_sync_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 16
) (
  input  logic             mac_clk,
  input  logic             mac_rst,
  input  logic             wr_en,
  input  logic [WIDTH-1:0] wr_data,
  input  logic             rd_en,
  output logic [WIDTH-1:0] rd_data,
  output logic             empty,
  output logic             almost_full
);

  localparam int AW = $clog2(DEPTH);
  localparam logic [AW:0] FULL_COUNT = (AW+1)'(DEPTH);
  localparam logic [AW:0] AF_COUNT   = (AW+1)'(DEPTH - `FIFO_AF_MARGIN);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [AW-1:0]    wr_ptr;
  logic [AW-1:0]    rd_ptr;
  logic [AW:0]      count;
  logic             do_wr;
  logic             do_rd;

  assign do_rd = rd_en && !empty;
  // A write into a full FIFO is lost
  assign do_wr = wr_en && count != FULL_COUNT;

  always_ff @(posedge mac_clk) begin
    if (mac_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + (AW+1)'(do_wr) - (AW+1)'(do_rd);
    end
  end

  always_ff @(posedge mac_clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  // Head is always presented
  assign rd_data     = mem[rd_ptr];
  assign empty       = count == '0;
  assign almost_full = count >= AF_COUNT;

endmodule

`default_nettype wire

/* udp_rx_pkg.sv */
`default_nettype none

package udp_rx_pkg;

  typedef logic [47:0] mac_addr_t;
  typedef logic [31:0] ip_addr_t;
  typedef logic [15:0] udp_port_t;
  typedef logic [63:0] data_word_t;
  typedef logic [7:0]  buf_addr_t;

  // Frame byte 0 sits in data[7:0]
  typedef struct packed {
    data_word_t data;
    logic [7:0] byte_valid;
    logic       good_frame;
    logic       bad_frame;
  } mac_rx_t;

  // Entry of the application data FIFO
  typedef struct packed {
    data_word_t data;
    logic       eof;
    logic       bad;
    logic       overrun;
  } app_word_t;

  // Entry of the application control FIFO
  typedef struct packed {
    ip_addr_t  src_ip;
    udp_port_t src_port;
  } app_ctrl_t;

  typedef struct packed {
    logic      enable;
    mac_addr_t mac;
    ip_addr_t  ip;
    udp_port_t port;
  } local_cfg_t;

  typedef enum logic [2:0] {
    PS_IDLE,
    PS_HDR1,
    PS_HDR2,
    PS_HDR3,
    PS_HDR4,
    PS_HDR5,
    PS_DATA,
    PS_DROP
  } parse_state_t;

  typedef enum logic {
    CPU_BUFFERING,
    CPU_WAITING
  } cpu_state_t;

  typedef enum logic [1:0] {
    OVR_RUN,
    OVR_OVER,
    OVR_WAIT_RELEASE
  } ovr_state_t;

endpackage

`default_nettype wire

/* udp_rx_defs.svh */
`ifndef UDP_RX_DEFS_SVH
`define UDP_RX_DEFS_SVH

// Application data FIFO, one entry per payload word
`define APP_FIFO_DEPTH 64

// Control FIFO, one entry per application frame
`define CTRL_FIFO_DEPTH 16

// Free entries left when almost-full asserts
`define FIFO_AF_MARGIN 4

// Words in one CPU buffer bank
`define CPU_BANK_WORDS 256

// APB map
// 12'h000 to 12'h7f8 is the buffer window, one 64-bit word every 8 bytes.
// The size register reads the committed word count and a write releases the bank.
`define APB_SIZE_ADDR 12'h800

`endif
